/* verilog/autotest_pkg.sv */
// Shared definitions for the SD-card test harness.
// The card is assumed initialised and block addressed.
// Only single-block read and write commands are supported.
`default_nettype none

package autotest_pkg;

  // card block geometry and the data token
  localparam int BLOCK_BYTES = 512;
  localparam logic [7:0] DATA_TOKEN = 8'hFE;

  typedef enum logic [5:0] {
    cmd_read_single  = 6'd17,
    cmd_write_single = 6'd24
  } sd_cmd_e;

  // UUT clock rate, taken from byte 8 of a vector block
  typedef enum logic [1:0] {
    sel_div8 = 2'd0,
    sel_div4 = 2'd1,
    sel_div2 = 2'd2
  } clk_sel_e;

  // shown on the debug word when sw_debug is 0
  typedef enum logic [3:0] {
    st_idle,
    st_cfg_rd,
    st_cfg_wait,
    st_vec_rd,
    st_vec_wait,
    st_run_uut,
    st_res_wr,
    st_res_wait,
    st_next,
    st_done
  } autotest_state_e;

  typedef enum logic [3:0] {
    h_idle,
    h_cmd,
    h_r1,
    h_token,
    h_rd_data,
    h_wr_data,
    h_resp,
    h_busy_poll,
    h_finish
  } host_state_e;

endpackage

`default_nettype wire

/* verilog/spi_byte_engine.sv */
// SPI mode 0 master, one byte out and one byte in per request, MSB first.
// A byte takes 16 * SCLK_DIV clk cycles; xfer is ignored while busy.
// mosi keeps its last bit between bytes.
`timescale 1ns/100ps
`default_nettype none

module spi_byte_engine #(
  parameter int SCLK_DIV = 2
) (
  input  wire        clk,
  input  wire        rst,
  input  wire        xfer,
  input  wire  [7:0] tx_byte,
  output logic       busy,
  output logic       done,
  output logic [7:0] rx_byte,
  output logic       sclk,
  output logic       mosi,
  input  wire        miso
);

  localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shift_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      done    <= 1'b0;
      sclk    <= 1'b0;
      mosi    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (xfer) begin
          busy      <= 1'b1;
          shift_reg <= tx_byte;
          mosi      <= tx_byte[7];
          div_cnt   <= '0;
          bit_cnt   <= '0;
        end
      end else if (div_cnt == DIV_W'(SCLK_DIV - 1)) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (!sclk) begin
          // rising edge, sample miso into the freed low bit
          shift_reg <= {shift_reg[6:0], miso};
        end else if (bit_cnt == 3'd7) begin
          busy    <= 1'b0;
          done    <= 1'b1;
          rx_byte <= shift_reg;
        end else begin
          // falling edge, next bit out
          bit_cnt <= bit_cnt + 3'd1;
          mosi    <= shift_reg[7];
        end
      end else begin
        div_cnt <= div_cnt + DIV_W'(1);
      end
    end
  end

  // the host waits for done before asking again
  a_no_xfer_when_busy: assert property (@(posedge clk) disable iff (rst) !(xfer && busy));

endmodule

`default_nettype wire

/* verilog/sd_block_host.sv */
// Single-block read (CMD17) and write (CMD24) over the SPI byte engine.
// No card init, no CRC check; the command CRC byte is sent as FF.
// Any nonzero R1, bad data response or poll timeout sets err.
// Write data is fetched byte by byte: wr_req, then wr_data one cycle later.
`timescale 1ns/100ps
`default_nettype none

module sd_block_host #(
  parameter int POLL_LIMIT = 64
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         r_block,
  input  wire         w_block,
  input  wire  [31:0] block_addr,
  output logic        busy,
  output logic        err,
  output logic        rd_valid,
  output logic [7:0]  rd_data,
  output logic        wr_req,
  input  wire  [7:0]  wr_data,
  output logic        cs,
  output logic        xfer,
  output logic [7:0]  tx_byte,
  input  wire         eng_busy,
  input  wire         done,
  input  wire  [7:0]  rx_byte
);
  import autotest_pkg::*;

  host_state_e state;
  sd_cmd_e     opcode;
  logic [47:0] cmd_buf;
  logic [15:0] cnt;
  logic        is_write;
  logic        wait_rx;
  logic        wr_pending;
  logic        data_slot;
  logic        poll_out;

  assign opcode    = w_block ? cmd_write_single : cmd_read_single;
  // write bytes 2 .. BLOCK_BYTES+1 carry block data
  assign data_slot = (cnt >= 16'd2) && (cnt < 16'(BLOCK_BYTES + 2));
  assign poll_out  = (cnt == 16'(POLL_LIMIT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= h_idle;
      busy       <= 1'b0;
      err        <= 1'b0;
      cs         <= 1'b1;
      xfer       <= 1'b0;
      rd_valid   <= 1'b0;
      wr_req     <= 1'b0;
      wait_rx    <= 1'b0;
      wr_pending <= 1'b0;
      is_write   <= 1'b0;
      cnt        <= '0;
    end else begin
      xfer     <= 1'b0;
      rd_valid <= 1'b0;
      wr_req   <= 1'b0;
      case (state)
        h_idle: begin
          if (r_block || w_block) begin
            busy     <= 1'b1;
            err      <= 1'b0;
            cs       <= 1'b0;
            is_write <= w_block;
            cnt      <= '0;
            cmd_buf  <= {2'b01, opcode, block_addr, 8'hFF};
            state    <= h_cmd;
          end
        end
        h_finish: begin
          cs    <= 1'b1;
          busy  <= 1'b0;
          state <= h_idle;
        end
        default: begin
          if (wait_rx) begin
            if (done) begin
              wait_rx <= 1'b0;
              cnt     <= cnt + 16'd1;
              case (state)
                h_cmd: begin
                  if (cnt == 16'd5) begin
                    cnt   <= '0;
                    state <= h_r1;
                  end
                end
                h_r1: begin
                  if (rx_byte == 8'h00) begin
                    cnt   <= '0;
                    state <= is_write ? h_wr_data : h_token;
                  end else if (rx_byte != 8'hFF || poll_out) begin
                    err   <= 1'b1;
                    state <= h_finish;
                  end
                end
                h_token: begin
                  if (rx_byte == DATA_TOKEN) begin
                    cnt   <= '0;
                    state <= h_rd_data;
                  end else if (poll_out) begin
                    err   <= 1'b1;
                    state <= h_finish;
                  end
                end
                h_rd_data: begin
                  if (cnt < 16'(BLOCK_BYTES)) begin
                    rd_data  <= rx_byte;
                    rd_valid <= 1'b1;
                  end
                  // two CRC bytes follow the data and are dropped
                  if (cnt == 16'(BLOCK_BYTES + 1)) state <= h_finish;
                end
                h_wr_data: begin
                  if (cnt == 16'(BLOCK_BYTES + 3)) begin
                    cnt   <= '0;
                    state <= h_resp;
                  end
                end
                h_resp: begin
                  if ((rx_byte & 8'h1F) == 8'h05) begin
                    cnt   <= '0;
                    state <= h_busy_poll;
                  end else if (rx_byte != 8'hFF || poll_out) begin
                    err   <= 1'b1;
                    state <= h_finish;
                  end
                end
                h_busy_poll: begin
                  // card holds miso low while it programs
                  if (rx_byte == 8'hFF) begin
                    state <= h_finish;
                  end else if (poll_out) begin
                    err   <= 1'b1;
                    state <= h_finish;
                  end
                end
                default: state <= h_finish;
              endcase
            end
          end else if (wr_pending) begin
            // wr_data is valid the cycle after wr_req
            if (!wr_req) begin
              xfer       <= 1'b1;
              tx_byte    <= wr_data;
              wait_rx    <= 1'b1;
              wr_pending <= 1'b0;
            end
          end else if (!eng_busy) begin
            if (state == h_wr_data && data_slot) begin
              wr_req     <= 1'b1;
              wr_pending <= 1'b1;
            end else begin
              xfer    <= 1'b1;
              wait_rx <= 1'b1;
              if (state == h_cmd) begin
                tx_byte <= cmd_buf[47:40];
                cmd_buf <= {cmd_buf[39:0], 8'hFF};
              end else if (state == h_wr_data && cnt == 16'd1) begin
                tx_byte <= DATA_TOKEN;
              end else begin
                tx_byte <= 8'hFF;
              end
            end
          end
        end
      endcase
    end
  end

  // card deselected whenever no transaction is open
  a_cs_idle_high: assert property (@(posedge clk) disable iff (rst) !busy |-> cs);

endmodule

`default_nettype wire

/* verilog/uut_clk_gen.sv */
// UUT clock as a registered divide of clk by 8, 4 or 2.
// No full-rate option; a new rate takes effect within one divided period.
`timescale 1ns/100ps
`default_nettype none

module uut_clk_gen (
  input  wire                    clk,
  input  wire                    rst,
  input  wire autotest_pkg::clk_sel_e clk_sel,
  output logic                   clk_uut
);
  import autotest_pkg::*;

  logic [2:0] div_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
      clk_uut <= 1'b0;
    end else begin
      div_cnt <= div_cnt + 3'd1;
      // output flop keeps the muxed bit glitch free
      case (clk_sel)
        sel_div8: clk_uut <= div_cnt[2];
        sel_div4: clk_uut <= div_cnt[1];
        default:  clk_uut <= div_cnt[0];
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/autotest_fsm.sv */
// Harness sequencer: config block, then per vector read, UUT run, result write.
// Stops with error and done on the first card error.
// Operands and result are at most 32 bits, stored little endian on the card.
// end_uut is synchronised here; output_from_uut must be stable once it rises.
`timescale 1ns/100ps
`default_nettype none

module autotest_fsm #(
  parameter int          INPUT_SIZE_1 = 32,
  parameter int          INPUT_SIZE_2 = 32,
  parameter int          OUTPUT_SIZE  = 32,
  parameter logic [31:0] CONFIG_BLOCK = 32'd0,
  parameter logic [31:0] RESULT_BASE  = 32'd256
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start,
  input  wire                     busy,
  input  wire                     err,
  output logic                    r_block,
  output logic                    w_block,
  output logic [31:0]             block_addr,
  input  wire                     rd_valid,
  input  wire  [7:0]              rd_data,
  input  wire                     wr_req,
  output logic [7:0]              wr_data,
  output logic                    rst_uut,
  input  wire                     end_uut,
  output logic [INPUT_SIZE_1-1:0] input_to_uut_1,
  output logic [INPUT_SIZE_2-1:0] input_to_uut_2,
  input  wire  [OUTPUT_SIZE-1:0]  output_from_uut,
  output autotest_pkg::clk_sel_e  clk_sel,
  input  wire  [1:0]              sw_debug,
  output logic [31:0]             debug_signal
);
  import autotest_pkg::*;

  autotest_state_e state;
  logic [9:0]  byte_cnt;
  logic [7:0]  vec_count;
  logic [7:0]  vec_idx;
  logic [31:0] op1;
  logic [31:0] op2;
  logic [31:0] last_result;
  logic [1:0]  end_sync;
  logic        done_flag;
  logic        error_flag;
  logic        host_idle;

  // a pulse in flight counts as busy until the host raises busy
  assign host_idle      = !busy && !r_block && !w_block;
  assign input_to_uut_1 = op1[INPUT_SIZE_1-1:0];
  assign input_to_uut_2 = op2[INPUT_SIZE_2-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      r_block     <= 1'b0;
      w_block     <= 1'b0;
      block_addr  <= '0;
      rst_uut     <= 1'b1;
      clk_sel     <= sel_div8;
      byte_cnt    <= '0;
      vec_count   <= '0;
      vec_idx     <= '0;
      last_result <= '0;
      end_sync    <= '0;
      done_flag   <= 1'b0;
      error_flag  <= 1'b0;
    end else begin
      r_block  <= 1'b0;
      w_block  <= 1'b0;
      end_sync <= {end_sync[0], end_uut};
      if (rd_valid || wr_req) byte_cnt <= byte_cnt + 10'd1;
      case (state)
        st_idle, st_done: begin
          if (start) begin
            done_flag  <= 1'b0;
            error_flag <= 1'b0;
            vec_idx    <= '0;
            state      <= st_cfg_rd;
          end
        end
        st_cfg_rd: begin
          if (host_idle) begin
            r_block    <= 1'b1;
            block_addr <= CONFIG_BLOCK;
            byte_cnt   <= '0;
            state      <= st_cfg_wait;
          end
        end
        st_cfg_wait: begin
          if (rd_valid && byte_cnt == 10'd0) vec_count <= rd_data;
          if (host_idle) begin
            if (err) begin
              error_flag <= 1'b1;
              done_flag  <= 1'b1;
              state      <= st_done;
            end else if (vec_count == 8'd0) begin
              done_flag <= 1'b1;
              state     <= st_done;
            end else begin
              vec_idx <= 8'd1;
              state   <= st_vec_rd;
            end
          end
        end
        st_vec_rd: begin
          if (host_idle) begin
            r_block    <= 1'b1;
            block_addr <= CONFIG_BLOCK + 32'(vec_idx);
            byte_cnt   <= '0;
            state      <= st_vec_wait;
          end
        end
        st_vec_wait: begin
          if (rd_valid && byte_cnt == 10'd8) clk_sel <= clk_sel_e'(rd_data[1:0]);
          if (host_idle) begin
            if (err) begin
              error_flag <= 1'b1;
              done_flag  <= 1'b1;
              state      <= st_done;
            end else begin
              rst_uut <= 1'b0;
              state   <= st_run_uut;
            end
          end
        end
        st_run_uut: begin
          if (end_sync[1]) begin
            last_result <= 32'(output_from_uut);
            rst_uut     <= 1'b1;
            state       <= st_res_wr;
          end
        end
        st_res_wr: begin
          if (host_idle) begin
            w_block    <= 1'b1;
            block_addr <= RESULT_BASE + 32'(vec_idx) - 32'd1;
            byte_cnt   <= '0;
            state      <= st_res_wait;
          end
        end
        st_res_wait: begin
          if (host_idle) begin
            if (err) begin
              error_flag <= 1'b1;
              done_flag  <= 1'b1;
              state      <= st_done;
            end else begin
              state <= st_next;
            end
          end
        end
        st_next: begin
          if (vec_idx == vec_count) begin
            done_flag <= 1'b1;
            state     <= st_done;
          end else begin
            vec_idx <= vec_idx + 8'd1;
            state   <= st_vec_rd;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // operand bytes land while the UUT is held in reset
  always_ff @(posedge clk) begin
    if (rd_valid && state == st_vec_wait) begin
      if (byte_cnt < 10'd4) op1[8*byte_cnt[1:0] +: 8] <= rd_data;
      else if (byte_cnt < 10'd8) op2[8*byte_cnt[1:0] +: 8] <= rd_data;
    end
    // result bytes first, zero padding after
    if (wr_req) wr_data <= (byte_cnt < 10'd4) ? last_result[8*byte_cnt[1:0] +: 8] : 8'h00;
  end

  always_comb begin
    case (sw_debug)
      2'd0:    debug_signal = 32'(state);
      2'd1:    debug_signal = 32'(vec_idx);
      2'd2:    debug_signal = last_result;
      default: debug_signal = {done_flag, error_flag, 22'd0, vec_count};
    endcase
  end

  // one request at a time, and never into a busy host
  a_one_request: assert property (@(posedge clk) disable iff (rst)
    !(r_block && w_block) && !((r_block || w_block) && busy));

endmodule

`default_nettype wire

/* verilog/autotest_module.sv */
// Top level of the SD-card test harness.
// Card must already be in SPI mode and block addressed.
// Operand and result widths up to 32 bits; clk_uut is clk divided by 8, 4 or 2.
`timescale 1ns/100ps
`default_nettype none

module autotest_module #(
  parameter int          INPUT_SIZE_1 = 32,
  parameter int          INPUT_SIZE_2 = 32,
  parameter int          OUTPUT_SIZE  = 32,
  parameter int          SCLK_DIV     = 2,
  parameter logic [31:0] CONFIG_BLOCK = 32'd0,
  parameter logic [31:0] RESULT_BASE  = 32'd256,
  parameter int          POLL_LIMIT   = 64
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start,
  output logic                    cs,
  output logic                    sclk,
  output logic                    mosi,
  input  wire                     miso,
  output logic                    rst_uut,
  input  wire                     end_uut,
  output logic [INPUT_SIZE_1-1:0] input_to_uut_1,
  output logic [INPUT_SIZE_2-1:0] input_to_uut_2,
  input  wire  [OUTPUT_SIZE-1:0]  output_from_uut,
  output logic                    clk_uut,
  input  wire  [1:0]              sw_debug,
  output logic [31:0]             debug
);
  import autotest_pkg::*;

  // FSM to host
  logic        busy;
  logic        err;
  logic        r_block;
  logic        w_block;
  logic [31:0] block_addr;
  logic        rd_valid;
  logic [7:0]  rd_data;
  logic        wr_req;
  logic [7:0]  wr_data;
  // host to byte engine
  logic        xfer;
  logic [7:0]  tx_byte;
  logic        eng_busy;
  logic        eng_done;
  logic [7:0]  rx_byte;
  clk_sel_e    clk_sel;

  autotest_fsm #(
    .INPUT_SIZE_1(INPUT_SIZE_1),
    .INPUT_SIZE_2(INPUT_SIZE_2),
    .OUTPUT_SIZE(OUTPUT_SIZE),
    .CONFIG_BLOCK(CONFIG_BLOCK),
    .RESULT_BASE(RESULT_BASE)
  ) autotest_fsm_i (
    .clk(clk),
    .rst(rst),
    .start(start),
    .busy(busy),
    .err(err),
    .r_block(r_block),
    .w_block(w_block),
    .block_addr(block_addr),
    .rd_valid(rd_valid),
    .rd_data(rd_data),
    .wr_req(wr_req),
    .wr_data(wr_data),
    .rst_uut(rst_uut),
    .end_uut(end_uut),
    .input_to_uut_1(input_to_uut_1),
    .input_to_uut_2(input_to_uut_2),
    .output_from_uut(output_from_uut),
    .clk_sel(clk_sel),
    .sw_debug(sw_debug),
    .debug_signal(debug)
  );

  sd_block_host #(
    .POLL_LIMIT(POLL_LIMIT)
  ) sd_block_host_i (
    .clk(clk),
    .rst(rst),
    .r_block(r_block),
    .w_block(w_block),
    .block_addr(block_addr),
    .busy(busy),
    .err(err),
    .rd_valid(rd_valid),
    .rd_data(rd_data),
    .wr_req(wr_req),
    .wr_data(wr_data),
    .cs(cs),
    .xfer(xfer),
    .tx_byte(tx_byte),
    .eng_busy(eng_busy),
    .done(eng_done),
    .rx_byte(rx_byte)
  );

  spi_byte_engine #(
    .SCLK_DIV(SCLK_DIV)
  ) spi_byte_engine_i (
    .clk(clk),
    .rst(rst),
    .xfer(xfer),
    .tx_byte(tx_byte),
    .busy(eng_busy),
    .done(eng_done),
    .rx_byte(rx_byte),
    .sclk(sclk),
    .mosi(mosi),
    .miso(miso)
  );

  uut_clk_gen uut_clk_gen_i (
    .clk(clk),
    .rst(rst),
    .clk_sel(clk_sel),
    .clk_uut(clk_uut)
  );

endmodule

`default_nettype wire

/* dv/sd_card_model.sv */
// Behavioural SD card in SPI mode, block addressed, already initialised.
// Handles CMD17 and CMD24 only; CRC bytes are neither checked nor meaningful.
// A command to err_block is answered with R1 = 04 and nothing else.
// Blocks at or above BLOCKS read as FF and drop writes.
`timescale 1ns/100ps
`default_nettype none

module sd_card_model #(
  parameter int BLOCKS = 264
) (
  input  wire  cs,
  input  wire  sclk,
  input  wire  mosi,
  output logic miso
);
  import autotest_pkg::*;

  typedef enum {m_cmd, m_wr_token, m_wr_data} card_state_e;

  logic [7:0]  mem [BLOCKS*BLOCK_BYTES];
  logic [31:0] err_block;
  logic [7:0]  out_q [$];
  logic [7:0]  rx_sh;
  logic [7:0]  cur_byte;
  logic [47:0] cmd;
  logic [31:0] addr;
  card_state_e mstate;
  int          bit_n;
  int          cmd_n;
  int          wr_n;

  initial miso = 1'b1;

  task automatic take_byte(input logic [7:0] b);
    int i;
    case (mstate)
      m_cmd: begin
        // idle FF bytes are skipped until a start bit pattern shows up
        if (cmd_n != 0 || b[7:6] == 2'b01) begin
          cmd   = {cmd[39:0], b};
          cmd_n = cmd_n + 1;
          if (cmd_n == 6) begin
            cmd_n = 0;
            addr  = cmd[39:8];
            // one filler byte before R1 so the host has to poll
            out_q.push_back(8'hFF);
            if (addr == err_block) begin
              out_q.push_back(8'h04);
            end else begin
              out_q.push_back(8'h00);
              if (cmd[45:40] == cmd_read_single) begin
                out_q.push_back(8'hFF);
                out_q.push_back(DATA_TOKEN);
                for (i = 0; i < BLOCK_BYTES; i++) begin
                  if (addr < BLOCKS) out_q.push_back(mem[addr*BLOCK_BYTES + i]);
                  else out_q.push_back(8'hFF);
                end
                out_q.push_back(8'hA5);
                out_q.push_back(8'h5A);
              end else begin
                mstate = m_wr_token;
              end
            end
          end
        end
      end
      m_wr_token: begin
        if (b == DATA_TOKEN) begin
          wr_n   = 0;
          mstate = m_wr_data;
        end
      end
      default: begin
        if (wr_n < BLOCK_BYTES && addr < BLOCKS) mem[addr*BLOCK_BYTES + wr_n] = b;
        wr_n = wr_n + 1;
        // after two CRC bytes: data accepted, then two busy bytes
        if (wr_n == BLOCK_BYTES + 2) begin
          out_q.push_back(8'hE5);
          out_q.push_back(8'h00);
          out_q.push_back(8'h00);
          mstate = m_cmd;
        end
      end
    endcase
  endtask

  always @(negedge cs) begin
    bit_n    = 0;
    cmd_n    = 0;
    mstate   = m_cmd;
    cur_byte = 8'hFF;
    miso     = 1'b1;
    out_q.delete();
  end

  // mode 0: sample on rising sclk
  always @(posedge sclk) begin
    if (cs == 1'b0) begin
      rx_sh = {rx_sh[6:0], mosi};
      bit_n = bit_n + 1;
      if (bit_n == 8) begin
        bit_n = 0;
        take_byte(rx_sh);
      end
    end
  end

  // next bit out on falling sclk, new byte at a byte boundary
  always @(negedge sclk) begin
    if (cs == 1'b0) begin
      if (bit_n == 0) cur_byte = (out_q.size() > 0) ? out_q.pop_front() : 8'hFF;
      miso = cur_byte[7 - bit_n];
    end
  end

endmodule

`default_nettype wire

/* dv/autotest_tb.sv */
// Testbench for the SD-card harness with an adder as the UUT.
// Run 1 goes through all table rows; run 2 injects R1 = 04 on one vector block.
// The card model memory is preloaded through hierarchical references.
`timescale 1ns/100ps
`default_nettype none

module autotest_tb;
  import autotest_pkg::*;

  localparam int          N_VEC        = 5;
  localparam int          ERR_ROW      = 3;
  localparam int          CARD_BLOCKS  = 264;
  localparam logic [31:0] CONFIG_BLOCK = 32'd0;
  localparam logic [31:0] RESULT_BASE  = 32'd256;
  // 32 engine cycles per byte plus host handshake overhead
  localparam int BYTE_CYCLES = 40;
  localparam int MAX_CYCLES  = 2 * (2 * N_VEC + 1) * 530 * BYTE_CYCLES + 20000;

  logic        clk;
  logic        rst;
  logic        start;
  wire         cs;
  wire         sclk;
  wire         mosi;
  wire         miso;
  wire         rst_uut;
  logic        end_uut;
  wire  [31:0] input_to_uut_1;
  wire  [31:0] input_to_uut_2;
  logic [31:0] output_from_uut;
  wire         clk_uut;
  logic [1:0]  sw_debug;
  wire  [31:0] debug;

  // operand 1, operand 2, clk_sel, error flag (run 2 only), expected sum
  logic [31:0] op1_tab [N_VEC] = '{32'h0000_0001, 32'hFFFF_FFFF, 32'h1234_5678,
                                   32'h8000_0000, 32'h0BAD_F00D};
  logic [31:0] op2_tab [N_VEC] = '{32'h0000_0002, 32'h0000_0002, 32'h1111_1111,
                                   32'h8000_0000, 32'h0000_1001};
  logic [1:0]  sel_tab [N_VEC] = '{2'd0, 2'd1, 2'd2, 2'd1, 2'd0};
  logic        err_tab [N_VEC] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
  logic [31:0] sum_tab [N_VEC] = '{32'h0000_0003, 32'h0000_0001, 32'h2345_6789,
                                   32'h0000_0000, 32'h0BAE_000E};

  int   errors;
  int   cycles;
  int   vec_seen;
  int   uut_edges;
  logic run_active;

  autotest_module #(
    .SCLK_DIV(2),
    .CONFIG_BLOCK(CONFIG_BLOCK),
    .RESULT_BASE(RESULT_BASE)
  ) autotest_module_i (
    .clk(clk),
    .rst(rst),
    .start(start),
    .cs(cs),
    .sclk(sclk),
    .mosi(mosi),
    .miso(miso),
    .rst_uut(rst_uut),
    .end_uut(end_uut),
    .input_to_uut_1(input_to_uut_1),
    .input_to_uut_2(input_to_uut_2),
    .output_from_uut(output_from_uut),
    .clk_uut(clk_uut),
    .sw_debug(sw_debug),
    .debug(debug)
  );

  sd_card_model #(.BLOCKS(CARD_BLOCKS)) card_i (
    .cs(cs),
    .sclk(sclk),
    .mosi(mosi),
    .miso(miso)
  );

  always #4 clk = ~clk;

  function automatic logic [7:0] fill_byte(input int idx);
    logic [31:0] a;
    a = idx;
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
  endfunction

  function automatic int period_for(input logic [1:0] sel);
    if (sel == 2'd0) return 8;
    else if (sel == 2'd1) return 4;
    return 2;
  endfunction

  // adder UUT with its result three clk_uut edges after release
  always @(posedge clk_uut or posedge rst_uut) begin
    if (rst_uut) begin
      uut_edges <= 0;
      end_uut   <= 1'b0;
    end else if (uut_edges < 3) begin
      uut_edges <= uut_edges + 1;
      if (uut_edges == 2) begin
        end_uut         <= 1'b1;
        output_from_uut <= input_to_uut_1 + input_to_uut_2;
      end
    end
  end

  always @(negedge rst_uut) begin : vector_check
    int  row;
    time t0;
    time t1;
    if (run_active) begin
      row      = vec_seen;
      vec_seen = vec_seen + 1;
      assert (row < N_VEC) else begin
        errors++;
        $display("UUT was released more often than the vector count allows");
      end
      if (row < N_VEC) begin
        assert (input_to_uut_1 == op1_tab[row]) else begin
          errors++;
          $display("Error: input_to_uut_1 = %h, expected %h", input_to_uut_1, op1_tab[row]);
        end
        assert (input_to_uut_2 == op2_tab[row]) else begin
          errors++;
          $display("Error: input_to_uut_2 = %h, expected %h", input_to_uut_2, op2_tab[row]);
        end
        @(posedge clk_uut);
        t0 = $time;
        @(posedge clk_uut);
        t1 = $time;
        assert ((t1 - t0) / 8 == period_for(sel_tab[row])) else begin
          errors++;
          $display("Error: clk_uut period = %h, expected %h", (t1 - t0) / 8,
                   period_for(sel_tab[row]));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  task automatic load_card();
    int i;
    for (i = 0; i < CARD_BLOCKS * BLOCK_BYTES; i++) card_i.mem[i] = fill_byte(i);
    card_i.mem[CONFIG_BLOCK * BLOCK_BYTES] = 8'(N_VEC);
    for (i = 0; i < N_VEC; i++) begin
      card_i.mem[(CONFIG_BLOCK + i + 1) * BLOCK_BYTES + 0] = op1_tab[i][7:0];
      card_i.mem[(CONFIG_BLOCK + i + 1) * BLOCK_BYTES + 1] = op1_tab[i][15:8];
      card_i.mem[(CONFIG_BLOCK + i + 1) * BLOCK_BYTES + 2] = op1_tab[i][23:16];
      card_i.mem[(CONFIG_BLOCK + i + 1) * BLOCK_BYTES + 3] = op1_tab[i][31:24];
      card_i.mem[(CONFIG_BLOCK + i + 1) * BLOCK_BYTES + 4] = op2_tab[i][7:0];
      card_i.mem[(CONFIG_BLOCK + i + 1) * BLOCK_BYTES + 5] = op2_tab[i][15:8];
      card_i.mem[(CONFIG_BLOCK + i + 1) * BLOCK_BYTES + 6] = op2_tab[i][23:16];
      card_i.mem[(CONFIG_BLOCK + i + 1) * BLOCK_BYTES + 7] = op2_tab[i][31:24];
      card_i.mem[(CONFIG_BLOCK + i + 1) * BLOCK_BYTES + 8] = {6'd0, sel_tab[i]};
    end
  endtask

  task automatic clear_results();
    int idx;
    for (idx = RESULT_BASE * BLOCK_BYTES; idx < (RESULT_BASE + N_VEC) * BLOCK_BYTES; idx++)
      card_i.mem[idx] = fill_byte(idx);
  endtask

  task automatic run_harness();
    vec_seen   = 0;
    run_active = 1'b1;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start    = 1'b0;
    sw_debug = 2'd3;
    while (!debug[31]) @(negedge clk);
    run_active = 1'b0;
  endtask

  // rows below n_ok hold their sum and the rest keep the fill pattern
  task automatic check_results(input int n_ok);
    int          row;
    int          off;
    int          idx;
    logic [7:0]  exp;
    for (row = 0; row < N_VEC; row++) begin
      for (off = 0; off < BLOCK_BYTES; off++) begin
        idx = (RESULT_BASE + row) * BLOCK_BYTES + off;
        if (row >= n_ok) exp = fill_byte(idx);
        else if (off < 4) exp = sum_tab[row][8*off +: 8];
        else exp = 8'h00;
        assert (card_i.mem[idx] == exp) else begin
          errors++;
          $display("Error: result mem[%0d] byte %0d = %h, expected %h", row, off,
                   card_i.mem[idx], exp);
        end
      end
    end
  endtask

  task automatic check_debug(input logic [1:0] sel, input logic [31:0] exp);
    @(negedge clk);
    sw_debug = sel;
    @(negedge clk);
    assert (debug == exp) else begin
      errors++;
      $display("Error: debug (sw_debug %0d) = %h, expected %h", sel, debug, exp);
    end
  endtask

  task automatic expect_level(input string name, input logic actual, input logic exp);
    assert (actual === exp) else begin
      errors++;
      $display("Error: %s = %h, expected %h", name, actual, exp);
    end
  endtask

  initial begin
    clk             = 1'b0;
    rst             = 1'b1;
    start           = 1'b0;
    sw_debug        = 2'd0;
    end_uut         = 1'b0;
    output_from_uut = '0;
    errors          = 0;
    cycles          = 0;
    vec_seen        = 0;
    run_active      = 1'b0;
    card_i.err_block = 32'hFFFF_FFFF;
    load_card();
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    expect_level("rst_uut", rst_uut, 1'b1);
    expect_level("cs", cs, 1'b1);
    expect_level("sclk", sclk, 1'b0);
    expect_level("mosi", mosi, 1'b0);
    check_debug(2'd0, 32'(st_idle));

    // run 1 covers every vector
    run_harness();
    check_results(N_VEC);
    check_debug(2'd3, {1'b1, 1'b0, 22'd0, 8'(N_VEC)});
    check_debug(2'd1, 32'(N_VEC));
    check_debug(2'd2, sum_tab[N_VEC-1]);

    // run 2 with the card rejecting the flagged vector block
    clear_results();
    for (int i = 0; i < N_VEC; i++)
      if (err_tab[i]) card_i.err_block = CONFIG_BLOCK + i + 1;
    run_harness();
    assert (vec_seen == ERR_ROW) else begin
      errors++;
      $display("Error: rst_uut release count = %h, expected %h", vec_seen, ERR_ROW);
    end
    check_results(ERR_ROW);
    check_debug(2'd3, {1'b1, 1'b1, 22'd0, 8'(N_VEC)});
    check_debug(2'd2, sum_tab[ERR_ROW-1]);

    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
verilog/autotest_pkg.sv
verilog/spi_byte_engine.sv
verilog/sd_block_host.sv
verilog/uut_clk_gen.sv
verilog/autotest_fsm.sv
verilog/autotest_module.sv
dv/sd_card_model.sv
dv/autotest_tb.sv

/* Makefile */
# Verilator build and run of the SD-card harness testbench

VERILATOR ?= verilator
TOP       ?= autotest_tb
RTL_TOP   ?= autotest_module
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "Errors found" $(LOG)
	@grep -q "No errors" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
